/* src.f */
+incdir+verilog
verilog/dbg_pkg.sv
verilog/dbg_host_port.sv
verilog/dbg_regmap.sv
verilog/dbg_shared_mem.sv
verilog/dbg_data_mover.sv
verilog/dbg_cpu_ctrl.sv
verilog/dbg_wrap_top.sv
testbench/dbg_sva.sv
testbench/dbg_tb.sv

/* testbench/dbg_sva.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Handshake and mover rules, bound into the host port and the mover
// Inputs that a bound block does not have are tied to constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dbg_sva import dbg_pkg::*; (
  input logic     clk,
  input logic     rst_n,
  input logic     req_i,
  input logic     ack_i,
  input dbg_rsp_t rsp_i,
  input logic     busy_i,
  input logic     done_i,
  input logic     start_i
);

  ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack_i) |-> $past(req_i))
    else $error("ack_o rose while req_i was low");

  rsp_held: assert property (@(posedge clk) disable iff (!rst_n)
    (ack_i && $past(ack_i)) |-> $stable(rsp_i))
    else $error("rsp_o changed while ack_o was high");

  done_held: assert property (@(posedge clk) disable iff (!rst_n)
    (done_i && !start_i) |=> done_i)
    else $error("mover done fell without a new start");

endmodule

bind dbg_host_port dbg_sva u_sva (
  .clk     (clk),
  .rst_n   (rst_n),
  .req_i   (req_i),
  .ack_i   (ack_o),
  .rsp_i   (rsp_o),
  .busy_i  (1'b0),
  .done_i  (1'b0),
  .start_i (1'b0)
);

bind dbg_data_mover dbg_sva u_sva (
  .clk     (clk),
  .rst_n   (rst_n),
  .req_i   (1'b0),
  .ack_i   (1'b0),
  .rsp_i   ('0),
  .busy_i  (busy_o),
  .done_i  (done_o),
  .start_i (cfg_i.start)
);

/* testbench/dbg_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Table driven testbench for dbg_wrap_top, host and CPU modelled here
// Memory words 0 to 47 are preloaded before any read of them
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "dbg_config.svh"

module dbg_tb import dbg_pkg::*; ();

  localparam int ACK_LIMIT  = 20;            // Cycles per handshake phase
  localparam int POLL_LIMIT = 100;           // Repeated accesses per poll step

  typedef struct packed {
    logic     poll;                          // Repeat until the response matches
    dbg_cmd_t cmd;
    dbg_rsp_t exp;
    logic     halt;                          // Expected cpu_halt_o afterwards
  } step_t;

  logic                   clk;
  logic                   rst_n;
  logic                   req_i;
  dbg_cmd_t               cmd_i;
  logic                   ack_o;
  dbg_rsp_t               rsp_o;
  logic                   cpu_halted_i = 1'b0;
  logic                   cpu_halt_o;
  logic                   cpu_resume_o;
  logic [2:0]             halt_dly = '0;
  logic [31:0]            lfsr_q = 32'h72a0;
  logic [`DBG_DATA_W-1:0] mem_model [`DBG_MEM_DEPTH];
  logic                   build_halt = 1'b0;
  int                     pulse_cnt = 0;
  step_t                  steps [$];

  dbg_wrap_top u_dbg_wrap_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (req_i),
    .cmd_i        (cmd_i),
    .ack_o        (ack_o),
    .rsp_o        (rsp_o),
    .cpu_halted_i (cpu_halted_i),
    .cpu_halt_o   (cpu_halt_o),
    .cpu_resume_o (cpu_resume_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // CPU model, reports halted a few cycles after the halt request
  always @(negedge clk) begin
    halt_dly     <= {halt_dly[1:0], cpu_halt_o};
    cpu_halted_i <= halt_dly[2];
  end

  always @(posedge clk) begin
    if (rst_n && cpu_resume_o) begin
      pulse_cnt <= pulse_cnt + 1;            // One count per high cycle
    end
  end

  task automatic stop_run();
    $display("sim failed");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic report_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    stop_run();
  endtask

  task automatic wait_timeout(input string msg);
    $display("Timeout at %0t: %s", $time, msg);
    stop_run();
  endtask

  task automatic check_rsp(input dbg_rsp_t got, input dbg_rsp_t exp, input string what);
    if (got !== exp) begin
      report_error($sformatf("%s got rdata=%h err=%b, expected rdata=%h err=%b",
                             what, got.rdata, got.err, exp.rdata, exp.err));
    end
  endtask

  task automatic check_cpu(input logic got_halt, input logic exp_halt,
                           input int got_pulses, input int exp_pulses, input string what);
    if ((got_halt !== exp_halt) || (got_pulses != exp_pulses)) begin
      report_error($sformatf("%s got halt=%b pulses=%0d, expected halt=%b pulses=%0d",
                             what, got_halt, got_pulses, exp_halt, exp_pulses));
    end
  endtask

  task automatic check_cycles(input int got, input int exp, input string what);
    if (got != exp) begin
      report_error($sformatf("%s took %0d cycles, expected %0d", what, got, exp));
    end
  endtask

  task automatic check_level(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report_error($sformatf("%s is %b, expected %b", what, got, exp));
    end
  endtask

  // One four-phase transaction, driven on falling edges
  task automatic host_access(input dbg_cmd_t cmd, output dbg_rsp_t rsp);
    int n;
    @(negedge clk);
    cmd_i = cmd;
    req_i = 1'b1;
    n = 0;
    while (ack_o !== 1'b1) begin
      @(negedge clk);
      n++;
      if (n > ACK_LIMIT) wait_timeout("ack_o never rose after req_i");
    end
    check_cycles(n, 3, "req_i rise to ack_o rise");
    rsp = rsp_o;
    req_i = 1'b0;
    n = 0;
    while (ack_o !== 1'b0) begin
      @(negedge clk);
      n++;
      if (n > ACK_LIMIT) wait_timeout("ack_o stayed high after req_i fell");
    end
    check_cycles(n, 1, "req_i fall to ack_o fall");
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32 22 2 1
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    w = '0;
    for (int b = 0; b < 32; b++) begin
      lfsr_q = lfsr_step(lfsr_q);
      w = {w[30:0], lfsr_q[0]};
    end
    return w;
  endfunction

  function automatic void add_step(input logic poll, input dbg_op_e op,
                                   input logic [15:0] addr, input logic [31:0] wdata,
                                   input logic [31:0] rdata, input logic err);
    step_t s;
    s.poll      = poll;
    s.cmd.op    = op;
    s.cmd.addr  = addr;
    s.cmd.wdata = wdata;
    s.exp.rdata = rdata;
    s.exp.err   = err;
    if ((op == DBG_WRITE) && (addr == 16'h0000)) begin
      build_halt = wdata[0];
    end
    s.halt = build_halt;
    steps.push_back(s);
  endfunction

  function automatic void add_write(input logic [15:0] addr, input logic [31:0] data);
    add_step(1'b0, DBG_WRITE, addr, data, 32'h0, 1'b0);
    if (addr[15:12] == `DBG_REG_MEM) begin
      mem_model[addr[`DBG_MEM_AW-1:0]] = data;
    end
  endfunction

  function automatic void add_read(input logic [15:0] addr, input logic [31:0] data,
                                   input logic err);
    add_step(1'b0, DBG_READ, addr, 32'h0, data, err);
  endfunction

  function automatic void add_poll(input logic [15:0] addr, input logic [31:0] data);
    add_step(1'b1, DBG_READ, addr, 32'h0, data, 1'b0);
  endfunction

  function automatic void model_copy(input int src, input int dst, input int len);
    for (int k = 0; k < len; k++) begin
      mem_model[dst + k] = mem_model[src + k];   // Ascending, like the mover
    end
  endfunction

  function automatic void build_table();
    add_read(16'h1003, 32'h0, 1'b0);
    add_read(16'h0000, 32'h0, 1'b0);
    for (int i = 0; i < 48; i++) add_write(16'h8000 + 16'(i), rand_word());
    for (int i = 0; i < 48; i++) add_read(16'h8000 + 16'(i), mem_model[i], 1'b0);
    add_read(16'h4000, `DBG_BAD_DATA, 1'b1);
    add_step(1'b0, DBG_WRITE, 16'h4000, rand_word(), `DBG_BAD_DATA, 1'b1);
    add_read(16'h8040, `DBG_BAD_DATA, 1'b1);    // Past the last memory word
    add_write(16'h1001, 32'd40);
    add_write(16'h1002, 32'd0);
    add_write(16'h1003, 32'd1);                 // Zero length copy while done is low
    add_poll(16'h1003, 32'h2);
    add_read(16'h8028, mem_model[40], 1'b0);
    add_write(16'h1000, 32'd2);
    add_write(16'h1001, 32'd16);
    add_write(16'h1002, 32'd8);
    add_read(16'h1002, 32'd8, 1'b0);
    add_write(16'h1003, 32'd1);
    add_step(1'b0, DBG_WRITE, 16'h1000, 32'd5, 32'h0, 1'b1);   // Locked while busy
    add_poll(16'h1003, 32'h2);
    add_read(16'h1000, 32'd2, 1'b0);
    model_copy(2, 16, 8);
    for (int i = 14; i < 26; i++) add_read(16'h8000 + 16'(i), mem_model[i], 1'b0);
    add_write(16'h0000, 32'h1);
    add_poll(16'h0000, 32'h5);
    add_write(16'h0000, 32'h3);
    add_poll(16'h0000, 32'h7);
    add_write(16'h0000, 32'h1);
    add_write(16'h0000, 32'h3);
    add_write(16'h0000, 32'h0);
    add_poll(16'h0000, 32'h0);
  endfunction

  initial begin
    dbg_rsp_t got;
    int       tries;
    logic     resume_bit;
    int       exp_pulses;
    rst_n      = 1'b0;
    req_i      = 1'b0;
    cmd_i      = '0;
    resume_bit = 1'b0;
    exp_pulses = 0;
    build_table();
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    check_level(ack_o, 1'b0, "ack_o after reset");
    check_cpu(cpu_halt_o, 1'b0, pulse_cnt, 0, "run control after reset");
    foreach (steps[i]) begin
      host_access(steps[i].cmd, got);
      tries = 0;
      while (steps[i].poll && (got !== steps[i].exp)) begin
        tries++;
        if (tries > POLL_LIMIT) wait_timeout("polled register never reached its value");
        host_access(steps[i].cmd, got);
      end
      check_rsp(got, steps[i].exp, $sformatf("step %0d addr %h", i, steps[i].cmd.addr));
      if ((steps[i].cmd.op == DBG_WRITE) && (steps[i].cmd.addr == 16'h0000)) begin
        if (steps[i].cmd.wdata[1] && !resume_bit) exp_pulses++;   // 0 to 1 on resume
        resume_bit = steps[i].cmd.wdata[1];
      end
      check_cpu(cpu_halt_o, steps[i].halt, pulse_cnt, exp_pulses,
                $sformatf("step %0d run control", i));
    end
    $display("sim passed");
    $finish;
  end

endmodule

/* verilog/dbg_config.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fixed address map of the debug block, word addressed
// Region is taken from address bits 15 to 12
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef DBG_CONFIG_SVH
`define DBG_CONFIG_SVH

`define DBG_DATA_W     32          // Data word width
`define DBG_ADDR_W     16          // Host word address width
`define DBG_MEM_DEPTH  64          // Shared memory words
`define DBG_MEM_AW     6           // log2 of DBG_MEM_DEPTH

`define DBG_REG_CPU    4'h0        // Run control at 0x0000
`define DBG_REG_MOVE   4'h1        // Mover regs 0x1000 to 0x1003
`define DBG_REG_MEM    4'h8        // Scratch memory at 0x8000

`define DBG_BAD_DATA   32'hDEADBEEF

`endif

/* verilog/dbg_cpu_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Halt is a level, resume a single pulse per 0 to 1 change
// cpu_halted_i may be asynchronous to clk
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dbg_cpu_ctrl import dbg_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  cpu_ctrl_t ctrl_i,
  input  logic      cpu_halted_i,
  output logic      cpu_halt_o,
  output logic      cpu_resume_o,
  output logic      halted_o
);

  logic       resume_q;
  logic [1:0] halted_sync;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cpu_halt_o   <= 1'b0;
      cpu_resume_o <= 1'b0;
      resume_q     <= 1'b0;
      halted_sync  <= 2'b00;
    end else begin
      cpu_halt_o   <= ctrl_i.halt;
      resume_q     <= ctrl_i.resume;
      cpu_resume_o <= ctrl_i.resume && !resume_q;      // Rising edge only
      halted_sync  <= {halted_sync[0], cpu_halted_i};  // Two flop synchronizer
    end
  end

  assign halted_o = halted_sync[1];

endmodule

/* verilog/dbg_data_mover.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word copy inside the shared memory, ascending, two cycles per word
// Start is ignored while a copy runs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "dbg_config.svh"

module dbg_data_mover import dbg_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  mover_cfg_t             cfg_i,
  output mem_req_t               mem_o,
  input  logic [`DBG_DATA_W-1:0] mem_rdata_i,
  output logic                   busy_o,
  output logic                   done_o
);

  mover_state_e           state_q;
  logic [`DBG_MEM_AW-1:0] src_q;
  logic [`DBG_MEM_AW-1:0] dst_q;
  logic [`DBG_MEM_AW-1:0] cnt_q;             // Words still to copy

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MV_IDLE;
      src_q   <= '0;
      dst_q   <= '0;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        MV_IDLE, MV_DONE: begin
          if (cfg_i.start) begin
            src_q   <= cfg_i.src;
            dst_q   <= cfg_i.dst;
            cnt_q   <= cfg_i.len;
            state_q <= (cfg_i.len == '0) ? MV_DONE : MV_READ;
          end
        end
        MV_READ: state_q <= MV_WRITE;
        MV_WRITE: begin
          src_q   <= src_q + 1'b1;
          dst_q   <= dst_q + 1'b1;
          cnt_q   <= cnt_q - 1'b1;
          state_q <= (cnt_q == 1) ? MV_DONE : MV_READ;
        end
        default: state_q <= MV_IDLE;
      endcase
    end
  end

  always_comb begin
    mem_o.en    = (state_q == MV_READ) || (state_q == MV_WRITE);
    mem_o.we    = (state_q == MV_WRITE);
    mem_o.addr  = (state_q == MV_WRITE) ? dst_q : src_q;
    mem_o.wdata = mem_rdata_i;               // Word read in the previous cycle
  end

  assign busy_o = (state_q == MV_READ) || (state_q == MV_WRITE);
  assign done_o = (state_q == MV_DONE);

endmodule

/* verilog/dbg_host_port.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Four-phase req/ack slave; the host keeps cmd_i stable while req_i is high
// One command in flight, a new one is taken only after ack_o falls
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dbg_host_port import dbg_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     req_i,
  input  dbg_cmd_t cmd_i,
  output logic     ack_o,
  output dbg_rsp_t rsp_o,
  output logic     cmd_valid_o,
  output dbg_cmd_t cmd_o,
  input  logic     rsp_valid_i,
  input  dbg_rsp_t rsp_i
);

  typedef enum logic [1:0] {
    HP_IDLE,
    HP_BUSY,
    HP_ACK,
    HP_RELEASE
  } hp_state_e;

  hp_state_e state_q;
  logic      take_cmd;

  // Release accepts a request like idle, so a quick re-request keeps the latency
  assign take_cmd = ((state_q == HP_IDLE) || (state_q == HP_RELEASE)) && req_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= HP_IDLE;
      cmd_valid_o <= 1'b0;
      ack_o       <= 1'b0;
    end else begin
      cmd_valid_o <= take_cmd;               // One cycle pulse to the register map
      case (state_q)
        HP_IDLE, HP_RELEASE: begin
          state_q <= take_cmd ? HP_BUSY : HP_IDLE;
        end
        HP_BUSY: begin
          if (rsp_valid_i) begin
            ack_o   <= 1'b1;
            state_q <= HP_ACK;
          end
        end
        HP_ACK: begin
          if (!req_i) begin                  // Host has seen the response
            ack_o   <= 1'b0;
            state_q <= HP_RELEASE;
          end
        end
        default: state_q <= HP_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take_cmd) begin
      cmd_o <= cmd_i;
    end
    if ((state_q == HP_BUSY) && rsp_valid_i) begin
      rsp_o <= rsp_i;                        // Held until the next response
    end
  end

endmodule

/* verilog/dbg_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the debug block and its testbench
// Field widths follow dbg_config.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "dbg_config.svh"

package dbg_pkg;

  typedef enum logic {
    DBG_READ  = 1'b0,
    DBG_WRITE = 1'b1
  } dbg_op_e;

  typedef struct packed {
    dbg_op_e                op;
    logic [`DBG_ADDR_W-1:0] addr;
    logic [`DBG_DATA_W-1:0] wdata;
  } dbg_cmd_t;                             // 49 bits

  typedef struct packed {
    logic [`DBG_DATA_W-1:0] rdata;
    logic                   err;
  } dbg_rsp_t;                             // 33 bits

  typedef struct packed {
    logic [`DBG_MEM_AW-1:0] src;
    logic [`DBG_MEM_AW-1:0] dst;
    logic [`DBG_MEM_AW-1:0] len;
    logic                   start;         // Single cycle strobe
  } mover_cfg_t;                           // 19 bits

  typedef enum logic [1:0] {
    MV_IDLE,
    MV_READ,
    MV_WRITE,
    MV_DONE
  } mover_state_e;

  typedef struct packed {
    logic halt;
    logic resume;
  } cpu_ctrl_t;

  typedef struct packed {
    logic                   en;
    logic                   we;
    logic [`DBG_MEM_AW-1:0] addr;
    logic [`DBG_DATA_W-1:0] wdata;
  } mem_req_t;                             // 40 bits

endpackage

/* verilog/dbg_regmap.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Answers every command one cycle after cmd_valid_i
// Writes return rdata 0; unmapped addresses return DBG_BAD_DATA, err=1
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "dbg_config.svh"

module dbg_regmap import dbg_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cmd_valid_i,
  input  dbg_cmd_t               cmd_i,
  output logic                   rsp_valid_o,
  output dbg_rsp_t               rsp_o,
  output mem_req_t               mem_o,
  input  logic [`DBG_DATA_W-1:0] mem_rdata_i,
  output mover_cfg_t             mover_cfg_o,
  input  logic                   mover_busy_i,
  input  logic                   mover_done_i,
  output cpu_ctrl_t              cpu_ctrl_o,
  input  logic                   cpu_halted_i
);

  logic [3:0]             region;
  logic                   is_wr;
  logic                   cpu_hit;
  logic                   move_hit;
  logic                   mem_hit;
  logic                   unmapped;
  logic [1:0]             move_idx;
  logic                   cfg_locked;
  logic [`DBG_DATA_W-1:0] rd_data;
  logic [`DBG_DATA_W-1:0] rsp_data_q;
  logic                   rsp_mem_q;
  logic                   rsp_err_q;

  assign region   = cmd_i.addr[`DBG_ADDR_W-1 -: 4];
  assign is_wr    = (cmd_i.op == DBG_WRITE);
  assign cpu_hit  = (region == `DBG_REG_CPU) && (cmd_i.addr[11:0] == '0);
  assign move_hit = (region == `DBG_REG_MOVE) && (cmd_i.addr[11:2] == '0);
  assign mem_hit  = (region == `DBG_REG_MEM) && (cmd_i.addr[11:`DBG_MEM_AW] == '0);
  assign unmapped = !(cpu_hit || move_hit || mem_hit);
  assign move_idx = cmd_i.addr[1:0];
  // src, dst and len are frozen while a copy runs
  assign cfg_locked = move_hit && (move_idx != 2'd3) && mover_busy_i;

  always_comb begin
    mem_o.en    = cmd_valid_i && mem_hit;    // Port A, data returns next cycle
    mem_o.we    = is_wr;
    mem_o.addr  = cmd_i.addr[`DBG_MEM_AW-1:0];
    mem_o.wdata = cmd_i.wdata;
  end

  always_comb begin
    rd_data = '0;
    if (unmapped) begin
      rd_data = `DBG_BAD_DATA;
    end else if (!is_wr && cpu_hit) begin
      rd_data[2:0] = {cpu_halted_i, cpu_ctrl_o.resume, cpu_ctrl_o.halt};
    end else if (!is_wr && move_hit) begin
      case (move_idx)
        2'd0: rd_data[`DBG_MEM_AW-1:0] = mover_cfg_o.src;
        2'd1: rd_data[`DBG_MEM_AW-1:0] = mover_cfg_o.dst;
        2'd2: rd_data[`DBG_MEM_AW-1:0] = mover_cfg_o.len;
        default: rd_data[2:1] = {mover_busy_i, mover_done_i};
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid_o <= 1'b0;
      rsp_data_q  <= '0;
      rsp_mem_q   <= 1'b0;
      rsp_err_q   <= 1'b0;
      mover_cfg_o <= '0;
      cpu_ctrl_o  <= '0;
    end else begin
      rsp_valid_o       <= cmd_valid_i;
      mover_cfg_o.start <= 1'b0;
      if (cmd_valid_i) begin
        rsp_data_q <= rd_data;
        rsp_mem_q  <= mem_hit && !is_wr;     // Take rdata from port A
        rsp_err_q  <= unmapped || (is_wr && cfg_locked);
        if (is_wr && cpu_hit) begin
          cpu_ctrl_o.halt   <= cmd_i.wdata[0];
          cpu_ctrl_o.resume <= cmd_i.wdata[1];
        end
        if (is_wr && move_hit && !cfg_locked) begin
          case (move_idx)
            2'd0: mover_cfg_o.src <= cmd_i.wdata[`DBG_MEM_AW-1:0];
            2'd1: mover_cfg_o.dst <= cmd_i.wdata[`DBG_MEM_AW-1:0];
            2'd2: mover_cfg_o.len <= cmd_i.wdata[`DBG_MEM_AW-1:0];
            default: mover_cfg_o.start <= cmd_i.wdata[0];
          endcase
        end
      end
    end
  end

  assign rsp_o.rdata = rsp_mem_q ? mem_rdata_i : rsp_data_q;
  assign rsp_o.err   = rsp_err_q;

endmodule

/* verilog/dbg_shared_mem.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-port scratch RAM, one cycle read latency, read before write
// Same-word writes from both ports in one cycle are undefined
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "dbg_config.svh"

module dbg_shared_mem import dbg_pkg::*; (
  input  logic                   clk,
  input  mem_req_t               a_i,
  output logic [`DBG_DATA_W-1:0] a_rdata_o,
  input  mem_req_t               b_i,
  output logic [`DBG_DATA_W-1:0] b_rdata_o
);

  logic [`DBG_DATA_W-1:0] mem [`DBG_MEM_DEPTH];

  always_ff @(posedge clk) begin
    if (a_i.en) begin                        // Host port
      if (a_i.we) begin
        mem[a_i.addr] <= a_i.wdata;
      end
      a_rdata_o <= mem[a_i.addr];
    end
    if (b_i.en) begin                        // Mover port
      if (b_i.we) begin
        mem[b_i.addr] <= b_i.wdata;
      end
      b_rdata_o <= mem[b_i.addr];
    end
  end

endmodule

/* verilog/dbg_wrap_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Debug access block top, single clock domain except cpu_halted_i
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "dbg_config.svh"

module dbg_wrap_top import dbg_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     req_i,
  input  dbg_cmd_t cmd_i,
  output logic     ack_o,
  output dbg_rsp_t rsp_o,
  input  logic     cpu_halted_i,
  output logic     cpu_halt_o,
  output logic     cpu_resume_o
);

  dbg_cmd_t               host_cmd;
  logic                   host_cmd_valid;
  dbg_rsp_t               map_rsp;
  logic                   map_rsp_valid;
  mem_req_t               mem_a_req;
  mem_req_t               mem_b_req;
  logic [`DBG_DATA_W-1:0] mem_a_rdata;
  logic [`DBG_DATA_W-1:0] mem_b_rdata;
  mover_cfg_t             mover_cfg;
  logic                   mover_busy;
  logic                   mover_done;
  cpu_ctrl_t              cpu_ctrl;
  logic                   cpu_halted_sync;

  dbg_host_port u_host_port (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_i       (req_i),
    .cmd_i       (cmd_i),
    .ack_o       (ack_o),
    .rsp_o       (rsp_o),
    .cmd_valid_o (host_cmd_valid),
    .cmd_o       (host_cmd),
    .rsp_valid_i (map_rsp_valid),
    .rsp_i       (map_rsp)
  );

  dbg_regmap u_regmap (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_valid_i  (host_cmd_valid),
    .cmd_i        (host_cmd),
    .rsp_valid_o  (map_rsp_valid),
    .rsp_o        (map_rsp),
    .mem_o        (mem_a_req),
    .mem_rdata_i  (mem_a_rdata),
    .mover_cfg_o  (mover_cfg),
    .mover_busy_i (mover_busy),
    .mover_done_i (mover_done),
    .cpu_ctrl_o   (cpu_ctrl),
    .cpu_halted_i (cpu_halted_sync)
  );

  dbg_shared_mem u_shared_mem (
    .clk       (clk),
    .a_i       (mem_a_req),
    .a_rdata_o (mem_a_rdata),
    .b_i       (mem_b_req),
    .b_rdata_o (mem_b_rdata)
  );

  dbg_data_mover u_data_mover (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_i       (mover_cfg),
    .mem_o       (mem_b_req),
    .mem_rdata_i (mem_b_rdata),
    .busy_o      (mover_busy),
    .done_o      (mover_done)
  );

  dbg_cpu_ctrl u_cpu_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl_i       (cpu_ctrl),
    .cpu_halted_i (cpu_halted_i),
    .cpu_halt_o   (cpu_halt_o),
    .cpu_resume_o (cpu_resume_o),
    .halted_o     (cpu_halted_sync)
  );

endmodule
